/* Makefile */
# Verilator simulation of the controller testbench

.PHONY: sim clean

sim:
	verilator --binary -j 0 --top-module tb_ctrl -f filelist.f -o sim_ctrl
	./obj_dir/sim_ctrl > sim.log 2>&1 || true
	cat sim.log
	! grep -q "RESULT: FAIL" sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* ctrl_defs.svh */
//////////////////////////////////////////////////////////////////////
// controller configuration macros
// data width, fast interrupt lines and trap cause field sizes
//////////////////////////////////////////////////////////////////////

`ifndef CTRL_DEFS_SVH
`define CTRL_DEFS_SVH

// address and data width of the core
`define CTRL_XLEN 32

// number of fast interrupt lines
`define CTRL_NUM_FAST_IRQ 15

// cause code of fast interrupt 0, line n maps to base + n
`define CTRL_FAST_IRQ_BASE 16

// width of a trap cause, msb marks an interrupt
`define CTRL_CAUSE_W 6

`endif

/* ctrl_exc_detect.sv */
//////////////////////////////////////////////////////////////////////
// exception detection
// qualifies decoder flags, registers the requests and picks the
// winning exception together with its cause and trap value
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ctrl_defs.svh"

module ctrl_exc_detect import ctrl_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  id_insn_t              insn_i,
  input  priv_lvl_e             priv_i,
  input  logic                  mstatus_tw_i,
  input  logic                  load_err_i,
  input  logic                  store_err_i,
  input  logic [`CTRL_XLEN-1:0] lsu_addr_i,
  input  logic                  in_flush_i,
  output exc_info_t             exc_o,
  output logic                  special_req_o,
  output logic                  branch_block_o,
  output logic                  mret_o,
  output logic                  wfi_o,
  output logic                  csr_flush_o
);

  logic ecall;
  logic ebrk;
  logic fetch_err;
  logic illegal_umode;
  logic illegal_d, illegal_q;
  logic exc_req_d, exc_req_q;
  logic load_err_d, load_err_q;
  logic store_err_d, store_err_q;
  logic fetch_err_prio;
  logic illegal_prio;
  logic ecall_prio;
  logic ebrk_prio;
  logic store_prio;
  logic load_prio;

  //////////////////////////////////////////////////////////////////////
  // request qualification
  //////////////////////////////////////////////////////////////////////

  // decoder flags ignore valid, so gate them here
  assign ecall       = insn_i.ecall & insn_i.valid;
  assign ebrk        = insn_i.ebreak & insn_i.valid;
  assign fetch_err   = insn_i.fetch_err & insn_i.valid;
  assign mret_o      = insn_i.mret & insn_i.valid;
  assign wfi_o       = insn_i.wfi & insn_i.valid;
  assign csr_flush_o = insn_i.csr_flush & insn_i.valid;

  // mret needs M-mode, TW traps wfi out of U-mode
  assign illegal_umode = (priv_i != PRIV_LVL_M) & (mret_o | (mstatus_tw_i & wfi_o));

  // flops drop out in FLUSH so a handled request does not fire twice
  assign illegal_d   = ((insn_i.illegal & insn_i.valid) | illegal_umode) & ~in_flush_i;
  assign exc_req_d   = (ecall | ebrk | illegal_d | fetch_err) & ~in_flush_i;
  assign load_err_d  = load_err_i & ~in_flush_i;
  assign store_err_d = store_err_i & ~in_flush_i;

  // lsu strobes last one cycle and carry no ID valid
  assign special_req_o = mret_o | wfi_o | csr_flush_o | exc_req_d | load_err_i | store_err_i;

  // a branch only needs to back off for a broken fetch
  assign branch_block_o = fetch_err & ~in_flush_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      illegal_q   <= 1'b0;
      exc_req_q   <= 1'b0;
      load_err_q  <= 1'b0;
      store_err_q <= 1'b0;
    end else begin
      illegal_q   <= illegal_d;
      exc_req_q   <= exc_req_d;
      load_err_q  <= load_err_d;
      store_err_q <= store_err_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // priority pick
  //////////////////////////////////////////////////////////////////////

  // privileged spec order: ID faults first, then lsu faults
  always_comb begin
    fetch_err_prio = 1'b0;
    illegal_prio   = 1'b0;
    ecall_prio     = 1'b0;
    ebrk_prio      = 1'b0;
    store_prio     = 1'b0;
    load_prio      = 1'b0;
    if (fetch_err) begin
      fetch_err_prio = 1'b1;
    end else if (illegal_q) begin
      illegal_prio = 1'b1;
    end else if (ecall) begin
      ecall_prio = 1'b1;
    end else if (ebrk) begin
      ebrk_prio = 1'b1;
    end else if (store_err_q) begin
      store_prio = 1'b1;
    end else if (load_err_q) begin
      load_prio = 1'b1;
    end
  end

  always_comb begin
    exc_o.pending = exc_req_q | store_err_q | load_err_q;
    exc_o.cause   = EXC_CAUSE_NONE;
    exc_o.mtval   = '0;
    if (fetch_err_prio) begin
      exc_o.cause = EXC_CAUSE_INSN_ACCESS_FAULT;
      // second half of a split 32 bit fetch failed
      exc_o.mtval = insn_i.fetch_err_plus2 ? (insn_i.pc + 'd2) : insn_i.pc;
    end else if (illegal_prio) begin
      exc_o.cause = EXC_CAUSE_ILLEGAL_INSN;
      exc_o.mtval = insn_i.is_compressed ? {{(`CTRL_XLEN-16){1'b0}}, insn_i.instr_c}
                                         : insn_i.instr;
    end else if (ecall_prio) begin
      exc_o.cause = (priv_i == PRIV_LVL_M) ? EXC_CAUSE_ECALL_MMODE : EXC_CAUSE_ECALL_UMODE;
    end else if (ebrk_prio) begin
      exc_o.cause = EXC_CAUSE_BREAKPOINT;
    end else if (store_prio) begin
      exc_o.cause = EXC_CAUSE_STORE_ACCESS_FAULT;
      exc_o.mtval = lsu_addr_i;
    end else if (load_prio) begin
      exc_o.cause = EXC_CAUSE_LOAD_ACCESS_FAULT;
      exc_o.mtval = lsu_addr_i;
    end
  end

  // the instruction is retained into FLUSH, so exactly one source must still be named
  a_prio_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (in_flush_i && exc_o.pending) |->
      $onehot({fetch_err_prio, illegal_prio, ecall_prio, ebrk_prio, store_prio, load_prio}));

endmodule

/* ctrl_fsm.sv */
//////////////////////////////////////////////////////////////////////
// controller state machine
// boot, fetch redirect, CSR save and restore, NMI mode and the
// halt, retain and flush controls of the ID handshake
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ctrl_fsm import ctrl_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        insn_valid_i,
  input  exc_info_t   exc_i,
  input  logic        special_req_i,
  input  logic        branch_block_i,
  input  logic        mret_i,
  input  logic        wfi_i,
  input  logic        csr_flush_i,
  input  logic        branch_set_i,
  input  logic        jump_set_i,
  input  logic        stall_id_i,
  input  logic        handle_irq_i,
  input  exc_cause_e  irq_cause_i,
  input  logic        irq_pending_i,
  output fetch_ctrl_t fetch_o,
  output csr_ctrl_t   csr_o,
  output logic        id_in_ready_o,
  output logic        instr_valid_clear_o,
  output logic        flush_id_o,
  output logic        busy_o,
  output logic        nmi_mode_o,
  output logic        in_flush_o
);

  ctrl_fsm_e state_q, state_d;
  logic      nmi_mode_q, nmi_mode_d;
  logic      halt_if;
  logic      retain_id;
  logic      flush_id;

  //////////////////////////////////////////////////////////////////////
  // next state and outputs
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    fetch_o.instr_req = 1'b1;
    fetch_o.pc_set    = 1'b0;
    fetch_o.pc_mux    = PC_BOOT;
    fetch_o.exc_cause = EXC_CAUSE_NONE;
    csr_o             = '0;
    state_d           = state_q;
    nmi_mode_d        = nmi_mode_q;
    busy_o            = 1'b1;
    halt_if           = 1'b0;
    retain_id         = 1'b0;
    flush_id          = 1'b0;

    unique case (state_q)
      RESET: begin
        // load the boot address, no request yet
        fetch_o.instr_req = 1'b0;
        fetch_o.pc_set    = 1'b1;
        busy_o            = 1'b0;
        state_d           = BOOT_SET;
      end

      BOOT_SET: begin
        fetch_o.pc_set = 1'b1;
        state_d        = FIRST_FETCH;
      end

      WAIT_SLEEP: begin
        busy_o            = 1'b0;
        fetch_o.instr_req = 1'b0;
        halt_if           = 1'b1;
        flush_id          = 1'b1;
        state_d           = SLEEP;
      end

      SLEEP: begin
        fetch_o.instr_req = 1'b0;
        halt_if           = 1'b1;
        flush_id          = 1'b1;
        // any raised line wakes the core, mie only gates the trap
        if (irq_pending_i || handle_irq_i) begin
          state_d = FIRST_FETCH;
        end else begin
          busy_o = 1'b0;
        end
      end

      FIRST_FETCH: begin
        // wait for the first instruction to land in ID
        if (!stall_id_i) begin
          state_d = DECODE;
        end
        if (handle_irq_i) begin
          state_d = IRQ_TAKEN;
          halt_if = 1'b1;
        end
      end

      DECODE: begin
        // mux set early, only pc_set depends on the branch outcome
        fetch_o.pc_mux = PC_JUMP;

        // keep the instruction in ID, FLUSH sorts out what it wants
        if (special_req_i) begin
          retain_id = 1'b1;
          state_d   = FLUSH;
        end

        // a failed fetch must trap rather than jump
        if ((branch_set_i || jump_set_i) && insn_valid_i && !branch_block_i) begin
          fetch_o.pc_set = 1'b1;
        end

        // interrupts wait for a stalled instruction to finish
        if (handle_irq_i) begin
          if (stall_id_i) begin
            halt_if = 1'b1;
          end else if (!special_req_i) begin
            halt_if = 1'b1;
            state_d = IRQ_TAKEN;
          end
        end
      end

      FLUSH: begin
        halt_if  = 1'b1;
        flush_id = 1'b1;
        state_d  = DECODE;

        if (exc_i.pending) begin
          // trap, epc comes from the instruction in ID
          fetch_o.pc_set    = 1'b1;
          fetch_o.pc_mux    = PC_EXC;
          fetch_o.exc_cause = exc_i.cause;
          csr_o.save_id     = 1'b1;
          csr_o.save_cause  = 1'b1;
          csr_o.mtval       = exc_i.mtval;
        end else if (mret_i) begin
          fetch_o.pc_set     = 1'b1;
          fetch_o.pc_mux     = PC_ERET;
          csr_o.restore_mret = 1'b1;
          // leaving the nmi handler re-arms interrupts
          nmi_mode_d         = 1'b0;
        end else if (wfi_i) begin
          state_d = WAIT_SLEEP;
        end else if (csr_flush_i && handle_irq_i) begin
          // interrupt just enabled through a CSR write
          state_d = IRQ_TAKEN;
        end
      end

      IRQ_TAKEN: begin
        fetch_o.pc_mux = PC_EXC;
        // line may have dropped meanwhile, then just resume
        if (handle_irq_i) begin
          fetch_o.pc_set    = 1'b1;
          fetch_o.exc_cause = irq_cause_i;
          csr_o.save_if     = 1'b1;
          csr_o.save_cause  = 1'b1;
          if (irq_cause_i == EXC_CAUSE_IRQ_NM) begin
            nmi_mode_d = 1'b1;
          end
        end
        state_d = DECODE;
      end

      default: begin
        fetch_o.instr_req = 1'b0;
        state_d           = RESET;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // ID handshake
  //////////////////////////////////////////////////////////////////////

  assign id_in_ready_o = ~stall_id_i & ~halt_if & ~retain_id;

  // retained instructions stay valid unless flushed
  assign instr_valid_clear_o = ~(stall_id_i | retain_id) | flush_id;

  assign flush_id_o = flush_id;
  assign nmi_mode_o = nmi_mode_q;
  assign in_flush_o = (state_q == FLUSH);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= RESET;
      nmi_mode_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      nmi_mode_q <= nmi_mode_d;
    end
  end

  a_state_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {RESET, BOOT_SET, WAIT_SLEEP, SLEEP, FIRST_FETCH, DECODE, FLUSH,
                    IRQ_TAKEN});

  // every trap redirect must also record mcause
  a_exc_saves_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (fetch_o.pc_set && (fetch_o.pc_mux == PC_EXC)) |-> csr_o.save_cause);

endmodule

/* ctrl_irq_select.sv */
//////////////////////////////////////////////////////////////////////
// interrupt selection
// decides whether an interrupt is taken and encodes its cause
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ctrl_defs.svh"

module ctrl_irq_select import ctrl_pkg::*; (
  input  irqs_t      irqs_i,
  input  logic       irq_nm_i,
  input  logic       mie_i,
  input  logic       nmi_mode_i,
  output logic       handle_irq_o,
  output exc_cause_e cause_o
);

  logic [4:0] fast_id;
  logic       fast_any;

  assign fast_any = |irqs_i.irq_fast;

  // nmi ignores mie, nothing nests inside an nmi handler
  assign handle_irq_o = ~nmi_mode_i & (irq_nm_i | ((|irqs_i) & mie_i));

  // highest numbered fast line wins, later hits override
  always_comb begin
    fast_id = '0;
    for (int i = 0; i < `CTRL_NUM_FAST_IRQ; i++) begin
      if (irqs_i.irq_fast[i]) begin
        fast_id = 5'(i);
      end
    end
  end

  // NMI, fast, external, software, then timer
  always_comb begin
    if (irq_nm_i) begin
      cause_o = EXC_CAUSE_IRQ_NM;
    end else if (fast_any) begin
      cause_o = exc_cause_e'({1'b1, 5'(`CTRL_FAST_IRQ_BASE) + fast_id});
    end else if (irqs_i.irq_external) begin
      cause_o = EXC_CAUSE_IRQ_EXTERNAL_M;
    end else if (irqs_i.irq_software) begin
      cause_o = EXC_CAUSE_IRQ_SOFTWARE_M;
    end else begin
      // timer, or nothing at all when handle_irq is low
      cause_o = EXC_CAUSE_IRQ_TIMER_M;
    end
  end

  // a fast cause must point back at a line that is really raised
  always_comb begin
    if (cause_o[5] && cause_o[4] && (cause_o != EXC_CAUSE_IRQ_NM)) begin
      a_fast_cause_line: assert (irqs_i.irq_fast[4'(cause_o[4:0] - 5'(`CTRL_FAST_IRQ_BASE))]);
    end
  end

endmodule

/* ctrl_pkg.sv */
//////////////////////////////////////////////////////////////////////
// controller types
// states, fetch selects, trap causes and the bundles between blocks
//////////////////////////////////////////////////////////////////////

`include "ctrl_defs.svh"

package ctrl_pkg;

  // main controller states
  typedef enum logic [3:0] {
    RESET, BOOT_SET, WAIT_SLEEP, SLEEP, FIRST_FETCH, DECODE, FLUSH, IRQ_TAKEN
  } ctrl_fsm_e;

  // fetch address source
  typedef enum logic [1:0] {
    PC_BOOT, PC_JUMP, PC_EXC, PC_ERET
  } pc_sel_e;

  // only machine and user mode
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // mcause encoding, msb set for interrupts
  typedef enum logic [`CTRL_CAUSE_W-1:0] {
    EXC_CAUSE_NONE               = {1'b0, 5'd0},
    EXC_CAUSE_INSN_ACCESS_FAULT  = {1'b0, 5'd1},
    EXC_CAUSE_ILLEGAL_INSN       = {1'b0, 5'd2},
    EXC_CAUSE_BREAKPOINT         = {1'b0, 5'd3},
    EXC_CAUSE_LOAD_ACCESS_FAULT  = {1'b0, 5'd5},
    EXC_CAUSE_STORE_ACCESS_FAULT = {1'b0, 5'd7},
    EXC_CAUSE_ECALL_UMODE        = {1'b0, 5'd8},
    EXC_CAUSE_ECALL_MMODE        = {1'b0, 5'd11},
    EXC_CAUSE_IRQ_SOFTWARE_M     = {1'b1, 5'd3},
    EXC_CAUSE_IRQ_TIMER_M        = {1'b1, 5'd7},
    EXC_CAUSE_IRQ_EXTERNAL_M     = {1'b1, 5'd11},
    // fast lines 1..14 follow on from here
    EXC_CAUSE_IRQ_FAST_0         = {1'b1, 5'(`CTRL_FAST_IRQ_BASE)},
    EXC_CAUSE_IRQ_NM             = {1'b1, 5'd31}
  } exc_cause_e;

  // interrupt lines already qualified with mie
  typedef struct packed {
    logic                          irq_software;
    logic                          irq_timer;
    logic                          irq_external;
    logic [`CTRL_NUM_FAST_IRQ-1:0] irq_fast;
  } irqs_t;

  // instruction sitting in the ID stage with its decoder flags
  typedef struct packed {
    logic                  valid;
    logic [`CTRL_XLEN-1:0] instr;
    logic [15:0]           instr_c;
    logic                  is_compressed;
    logic                  fetch_err;
    logic                  fetch_err_plus2;
    logic [`CTRL_XLEN-1:0] pc;
    logic                  illegal;
    logic                  ecall;
    logic                  ebreak;
    logic                  mret;
    logic                  wfi;
    logic                  csr_flush;
  } id_insn_t;

  // exception chosen for the next FLUSH
  typedef struct packed {
    logic                  pending;
    exc_cause_e            cause;
    logic [`CTRL_XLEN-1:0] mtval;
  } exc_info_t;

  // toward the prefetcher and mcause
  typedef struct packed {
    logic       instr_req;
    logic       pc_set;
    pc_sel_e    pc_mux;
    exc_cause_e exc_cause;
  } fetch_ctrl_t;

  // strobes toward the CSR file
  typedef struct packed {
    logic                  save_if;
    logic                  save_id;
    logic                  save_cause;
    logic                  restore_mret;
    logic [`CTRL_XLEN-1:0] mtval;
  } csr_ctrl_t;

endpackage

/* ctrl_top.sv */
//////////////////////////////////////////////////////////////////////
// controller top level
// exception detection and interrupt selection feeding the FSM
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ctrl_defs.svh"

module ctrl_top import ctrl_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  id_insn_t              insn_i,
  input  logic                  branch_set_i,
  input  logic                  jump_set_i,
  input  logic                  stall_id_i,
  input  priv_lvl_e             priv_i,
  input  logic                  mstatus_mie_i,
  input  logic                  mstatus_tw_i,
  input  irqs_t                 irqs_i,
  input  logic                  irq_nm_i,
  input  logic                  load_err_i,
  input  logic                  store_err_i,
  input  logic [`CTRL_XLEN-1:0] lsu_addr_i,
  output fetch_ctrl_t           fetch_o,
  output csr_ctrl_t             csr_o,
  output logic                  id_in_ready_o,
  output logic                  instr_valid_clear_o,
  output logic                  flush_id_o,
  output logic                  busy_o,
  output logic                  nmi_mode_o
);

  exc_info_t  exc;
  exc_cause_e irq_cause;
  logic       special_req;
  logic       branch_block;
  logic       mret;
  logic       wfi;
  logic       csr_flush;
  logic       in_flush;
  logic       handle_irq;
  logic       irq_pending;

  // any line at all, used for wake-up
  assign irq_pending = |irqs_i;

  ctrl_exc_detect u_exc_detect (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .insn_i         (insn_i),
    .priv_i         (priv_i),
    .mstatus_tw_i   (mstatus_tw_i),
    .load_err_i     (load_err_i),
    .store_err_i    (store_err_i),
    .lsu_addr_i     (lsu_addr_i),
    .in_flush_i     (in_flush),
    .exc_o          (exc),
    .special_req_o  (special_req),
    .branch_block_o (branch_block),
    .mret_o         (mret),
    .wfi_o          (wfi),
    .csr_flush_o    (csr_flush)
  );

  ctrl_irq_select u_irq_select (
    .irqs_i       (irqs_i),
    .irq_nm_i     (irq_nm_i),
    .mie_i        (mstatus_mie_i),
    .nmi_mode_i   (nmi_mode_o),
    .handle_irq_o (handle_irq),
    .cause_o      (irq_cause)
  );

  ctrl_fsm u_fsm (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .insn_valid_i        (insn_i.valid),
    .exc_i               (exc),
    .special_req_i       (special_req),
    .branch_block_i      (branch_block),
    .mret_i              (mret),
    .wfi_i               (wfi),
    .csr_flush_i         (csr_flush),
    .branch_set_i        (branch_set_i),
    .jump_set_i          (jump_set_i),
    .stall_id_i          (stall_id_i),
    .handle_irq_i        (handle_irq),
    .irq_cause_i         (irq_cause),
    .irq_pending_i       (irq_pending),
    .fetch_o             (fetch_o),
    .csr_o               (csr_o),
    .id_in_ready_o       (id_in_ready_o),
    .instr_valid_clear_o (instr_valid_clear_o),
    .flush_id_o          (flush_id_o),
    .busy_o              (busy_o),
    .nmi_mode_o          (nmi_mode_o),
    .in_flush_o          (in_flush)
  );

endmodule

/* ctrl_vectors.txt */
# kind flags priv tw mie irqs nmi instr instr_c pc lsu exp_cause exp_sel exp_mtval msrc exp_cyc exp_nmi
# flags 1 valid 2 compr 4 ferr 8 plus2 10 ill 20 ecall 40 ebrk 80 mret 100 wfi 200 csrfl 400 jump 800 ld 1000 st 2000 stall 4000 rnd instr 8000 rnd lsu
# id stage faults
0 4005 3 0 0 00000 0 00000000 0000 00001000 00000000 01 2 00001000 0 1 0
0 400d 3 0 0 00000 0 00000000 0000 0000200e 00000000 01 2 00002010 0 1 0
0 4011 3 0 0 00000 0 00000000 0000 00001004 00000000 02 2 00000000 1 1 0
0 4013 3 0 0 00000 0 00000000 a5f3 00001008 00000000 02 2 0000a5f3 0 1 0
0 4021 3 0 0 00000 0 00000000 0000 0000100c 00000000 0b 2 00000000 0 1 0
0 4021 0 0 0 00000 0 00000000 0000 00001010 00000000 08 2 00000000 0 1 0
0 4041 3 0 0 00000 0 00000000 0000 00001014 00000000 03 2 00000000 0 1 0
0 4041 0 0 0 00000 0 00000000 0000 00001018 00000000 03 2 00000000 0 1 0
# lsu faults
0 8800 3 0 0 00000 0 00000000 0000 00000000 00000000 05 2 00000000 2 1 0
0 9000 3 0 0 00000 0 00000000 0000 00000000 00000000 07 2 00000000 2 1 0
0 0800 3 0 0 00000 0 00000000 0000 00000000 80000ffc 05 2 80000ffc 0 1 0
# several sources at once
0 4035 3 0 0 00000 0 00000000 0000 00001020 00000000 01 2 00001020 0 1 0
0 4071 3 0 0 00000 0 00000000 0000 00001024 00000000 02 2 00000000 1 1 0
0 4061 3 0 0 00000 0 00000000 0000 00001028 00000000 0b 2 00000000 0 1 0
0 5041 3 0 0 00000 0 00000000 0000 0000102c 12345678 03 2 00000000 0 1 0
0 1800 3 0 0 00000 0 00000000 0000 00000000 00004444 07 2 00004444 0 1 0
0 4821 3 0 0 00000 0 00000000 0000 00001030 00005555 0b 2 00000000 0 1 0
# user mode
0 0081 0 0 0 00000 0 30200073 0000 00001034 00000000 02 2 30200073 0 1 0
0 0101 0 1 0 00000 0 10500073 0000 00001038 00000000 02 2 10500073 0 1 0
# branches
0 4401 3 0 0 00000 0 00000000 0000 00001040 00000000 00 1 00000000 0 0 0
0 4405 3 0 0 00000 0 00000000 0000 00003000 00000000 01 2 00003000 0 1 0
# interrupts
0 0000 3 0 1 20000 0 00000000 0000 00000000 00000000 23 2 00000000 0 1 0
0 0000 3 0 1 10000 0 00000000 0000 00000000 00000000 27 2 00000000 0 1 0
0 0000 3 0 1 08000 0 00000000 0000 00000000 00000000 2b 2 00000000 0 1 0
0 0000 3 0 1 38000 0 00000000 0000 00000000 00000000 2b 2 00000000 0 1 0
0 0000 3 0 1 30000 0 00000000 0000 00000000 00000000 23 2 00000000 0 1 0
0 0000 3 0 1 00001 0 00000000 0000 00000000 00000000 30 2 00000000 0 1 0
0 0000 3 0 1 04000 0 00000000 0000 00000000 00000000 3e 2 00000000 0 1 0
0 0000 3 0 1 00024 0 00000000 0000 00000000 00000000 35 2 00000000 0 1 0
0 0000 3 0 1 08008 0 00000000 0000 00000000 00000000 33 2 00000000 0 1 0
0 4201 3 0 1 08000 0 00000000 0000 00001044 00000000 2b 2 00000000 0 2 0
# nmi and its mode flag
1 0000 3 0 0 10000 0 00000000 0000 00000000 00000000 00 0 00000000 0 5 0
0 0000 3 0 0 08000 1 00000000 0000 00000000 00000000 3f 2 00000000 0 1 1
1 0000 3 0 1 10000 0 00000000 0000 00000000 00000000 00 0 00000000 0 5 1
1 0000 3 0 1 00000 1 00000000 0000 00000000 00000000 00 0 00000000 0 5 1
0 4081 3 0 1 00000 0 00000000 0000 00001048 00000000 00 3 00000000 0 1 0
0 0000 3 0 1 10000 0 00000000 0000 00000000 00000000 27 2 00000000 0 1 0
# back-pressure and sleep
2 6001 3 0 1 10000 0 00000000 0000 0000104c 00000000 27 2 00000000 0 1 0
3 4101 3 0 1 10000 0 00000000 0000 00001050 00000000 27 2 00000000 0 0 0

/* filelist.f */
+incdir+.
ctrl_pkg.sv
ctrl_exc_detect.sv
ctrl_irq_select.sv
ctrl_fsm.sv
ctrl_top.sv
tb_ctrl.sv

/* tb_ctrl.sv */
//////////////////////////////////////////////////////////////////////
// controller testbench
// replays scenario vectors and checks redirect, cause and mtval
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ctrl_defs.svh"

module tb_ctrl import ctrl_pkg::*; ();

  logic                  clk;
  logic                  rst_n;
  id_insn_t              insn;
  logic                  branch_set;
  logic                  jump_set;
  logic                  stall_id;
  priv_lvl_e             priv;
  logic                  mie;
  logic                  tw;
  irqs_t                 irqs;
  logic                  irq_nm;
  logic                  load_err;
  logic                  store_err;
  logic [`CTRL_XLEN-1:0] lsu_addr;
  fetch_ctrl_t           fetch;
  csr_ctrl_t             csr;
  logic                  id_in_ready;
  logic                  instr_valid_clear;
  logic                  flush_id;
  logic                  busy;
  logic                  nmi_mode;

  // fields of the current vector row
  logic [31:0]           kind;
  logic [31:0]           flags;
  logic [31:0]           priv_f;
  logic [31:0]           tw_f;
  logic [31:0]           mie_f;
  logic [31:0]           irqs_f;
  logic [31:0]           nmi_f;
  logic [31:0]           instr_f;
  logic [31:0]           instr_c_f;
  logic [31:0]           pc_f;
  logic [31:0]           lsu_f;
  logic [31:0]           exp_cause;
  logic [31:0]           exp_sel;
  logic [31:0]           exp_mtval;
  logic [31:0]           msrc;
  logic [31:0]           exp_cyc;
  logic [31:0]           exp_nmi;
  logic [`CTRL_XLEN-1:0] exp_trap_val;
  integer                seed = 32'h6bf4_a1ff;

  // 100 ns period
  always #50 clk = ~clk;

  ctrl_top dut (
    .clk_i               (clk),
    .rst_ni              (rst_n),
    .insn_i              (insn),
    .branch_set_i        (branch_set),
    .jump_set_i          (jump_set),
    .stall_id_i          (stall_id),
    .priv_i              (priv),
    .mstatus_mie_i       (mie),
    .mstatus_tw_i        (tw),
    .irqs_i              (irqs),
    .irq_nm_i            (irq_nm),
    .load_err_i          (load_err),
    .store_err_i         (store_err),
    .lsu_addr_i          (lsu_addr),
    .fetch_o             (fetch),
    .csr_o               (csr),
    .id_in_ready_o       (id_in_ready),
    .instr_valid_clear_o (instr_valid_clear),
    .flush_id_o          (flush_id),
    .busy_o              (busy),
    .nmi_mode_o          (nmi_mode)
  );

  //////////////////////////////////////////////////////////////////////
  // compare helpers
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_cause(input string name, input exc_cause_e got, input exc_cause_e exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_pc_sel(input string name, input pc_sel_e got, input pc_sel_e exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_word(input string name, input logic [`CTRL_XLEN-1:0] got,
                            input logic [`CTRL_XLEN-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error %s got %h expected %h", name, got, exp));
    end
  endtask

  // CSR strobes and ID flush follow from the kind of redirect
  task automatic check_csr_strobes();
    logic is_exc;
    logic is_irq;
    logic is_eret;
    is_exc  = (exp_sel[1:0] == PC_EXC) && !exp_cause[5];
    is_irq  = (exp_sel[1:0] == PC_EXC) && exp_cause[5];
    is_eret = (exp_sel[1:0] == PC_ERET);
    check_word("save_id", 32'(csr.save_id), 32'(is_exc));
    check_word("save_if", 32'(csr.save_if), 32'(is_irq));
    check_word("save_cause", 32'(csr.save_cause), 32'(is_exc | is_irq));
    check_word("restore_mret", 32'(csr.restore_mret), 32'(is_eret));
    // a trap or a return drops the instruction left in ID
    if (!is_irq) begin
      check_word("flush_id", 32'(flush_id), 32'(is_exc | is_eret));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus and waits
  //////////////////////////////////////////////////////////////////////

  // pipeline quiet, privilege and mstatus bits left as they are
  task automatic drive_idle();
    insn       = '0;
    branch_set = 1'b0;
    jump_set   = 1'b0;
    stall_id   = 1'b0;
    irqs       = '0;
    irq_nm     = 1'b0;
    load_err   = 1'b0;
    store_err  = 1'b0;
  endtask

  // flags bit map follows the column note in the vector file
  task automatic drive_vector();
    logic [`CTRL_XLEN-1:0] word;
    word     = flags[14] ? $random(seed) : instr_f;
    lsu_addr = flags[15] ? $random(seed) : lsu_f;
    insn.valid           = flags[0];
    insn.instr           = word;
    insn.instr_c         = instr_c_f[15:0];
    insn.is_compressed   = flags[1];
    insn.fetch_err       = flags[2];
    insn.fetch_err_plus2 = flags[3];
    insn.pc              = pc_f;
    insn.illegal         = flags[4];
    insn.ecall           = flags[5];
    insn.ebreak          = flags[6];
    insn.mret            = flags[7];
    insn.wfi             = flags[8];
    insn.csr_flush       = flags[9];
    jump_set             = flags[10];
    load_err             = flags[11];
    store_err            = flags[12];
    stall_id             = flags[13];
    priv                 = priv_lvl_e'(priv_f[1:0]);
    tw                   = tw_f[0];
    mie                  = mie_f[0];
    irqs                 = irqs_t'(irqs_f[17:0]);
    irq_nm               = nmi_f[0];
    // mtval follows whichever value was really driven
    if (msrc == 32'd1) begin
      exp_trap_val = word;
    end else if (msrc == 32'd2) begin
      exp_trap_val = lsu_addr;
    end else begin
      exp_trap_val = exp_mtval;
    end
  endtask

  task automatic wait_pc_set(output int cycles);
    cycles = 0;
    while (fetch.pc_set !== 1'b1) begin
      @(negedge clk);
      #1;
      cycles++;
      if (cycles > 50) begin
        abort_run("timeout, no pc_set seen within 50 cycles");
      end
    end
  endtask

  task automatic wait_sleep();
    int cycles;
    cycles = 0;
    while (busy !== 1'b0) begin
      @(negedge clk);
      #1;
      cycles++;
      if (cycles > 50) begin
        abort_run("timeout, controller never went idle after WFI");
      end
    end
  endtask

  // kind 0 redirect, 1 quiet window, 2 stall then irq, 3 sleep then wake
  task automatic run_vector();
    int cycles;
    drive_vector();
    if (kind == 32'd1) begin
      for (int i = 0; i < int'(exp_cyc); i++) begin
        #1;
        check_word("pc_set", 32'(fetch.pc_set), 32'd0);
        @(negedge clk);
      end
    end else begin
      if (kind == 32'd2) begin
        // instruction held in ID, interrupt must wait
        for (int i = 0; i < 4; i++) begin
          #1;
          check_word("id_in_ready", 32'(id_in_ready), 32'd0);
          check_word("instr_valid_clear", 32'(instr_valid_clear), 32'd0);
          check_word("pc_set", 32'(fetch.pc_set), 32'd0);
          @(negedge clk);
        end
        stall_id = 1'b0;
      end
      if (kind == 32'd3) begin
        // lines held back until the core sleeps
        irqs = '0;
        #1;
        wait_sleep();
        @(negedge clk);
        insn = '0;
        irqs = irqs_t'(irqs_f[17:0]);
      end
      #1;
      wait_pc_set(cycles);
      check_pc_sel("pc_mux", fetch.pc_mux, pc_sel_e'(exp_sel[1:0]));
      check_cause("exc_cause", fetch.exc_cause, exc_cause_e'(exp_cause[5:0]));
      check_word("mtval", csr.mtval, exp_trap_val);
      check_csr_strobes();
      // wake-up latency is not fixed
      if (kind != 32'd3) begin
        check_word("redirect latency", 32'(cycles), exp_cyc);
      end
      @(negedge clk);
    end
    drive_idle();
    #1;
    check_word("nmi_mode", 32'(nmi_mode), exp_nmi);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int    fd;
    int    rc;
    int    fields;
    int    num_vectors;
    string line;
    clk         = 1'b0;
    rst_n       = 1'b0;
    priv        = PRIV_LVL_M;
    mie         = 1'b0;
    tw          = 1'b0;
    lsu_addr    = '0;
    num_vectors = 0;
    drive_idle();

    repeat (5) @(negedge clk);
    // still in reset, nothing active toward CSRs
    check_word("csr strobes",
               {28'd0, csr.save_if, csr.save_id, csr.save_cause, csr.restore_mret}, 32'd0);
    check_word("nmi_mode", 32'(nmi_mode), 32'd0);
    check_word("busy", 32'(busy), 32'd0);
    rst_n = 1'b1;
    #1;
    // boot address loaded without a request
    check_word("pc_set", 32'(fetch.pc_set), 32'd1);
    check_word("instr_req", 32'(fetch.instr_req), 32'd0);
    check_pc_sel("pc_mux", fetch.pc_mux, PC_BOOT);
    @(negedge clk);
    #1;
    check_word("pc_set", 32'(fetch.pc_set), 32'd1);
    check_word("instr_req", 32'(fetch.instr_req), 32'd1);
    check_pc_sel("pc_mux", fetch.pc_mux, PC_BOOT);
    // first fetch then decode
    @(negedge clk);

    fd = $fopen("ctrl_vectors.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open ctrl_vectors.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      rc   = $fgets(line, fd);
      if (rc > 0 && line.len() > 2 && line.getc(0) != "#") begin
        fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                         kind, flags, priv_f, tw_f, mie_f, irqs_f, nmi_f, instr_f,
                         instr_c_f, pc_f, lsu_f, exp_cause, exp_sel, exp_mtval, msrc,
                         exp_cyc, exp_nmi);
        if (fields != 17) begin
          abort_run($sformatf("malformed vector line %s", line));
        end
        @(negedge clk);
        run_vector();
        num_vectors++;
      end
    end
    $fclose(fd);

    if (num_vectors == 0) begin
      abort_run("no vectors were read from ctrl_vectors.txt");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule
